// File: common/drive_pkg.sv
package drive_pkg;

  // Carrier period in clock cycles
  localparam int period_len = 256;

  // Target of a table write
  typedef enum logic {
    TABLE_STM,
    TABLE_MOD
  } table_sel_e;

  // One write on the shared table port
  // STM data is {intensity, phase}, MOD data uses the low byte only
  typedef struct packed {
    logic        valid;
    table_sel_e  sel;
    logic [15:0] addr;
    logic [15:0] data;
  } mem_wr_t;

  // mod_cycle of 0 selects all 256 samples
  typedef struct packed {
    logic [7:0]  mod_cycle;
    logic [15:0] freq_div;
  } mod_settings_t;

  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_t;

  // One transducer per beat, no back-pressure
  typedef struct packed {
    logic        valid;
    logic [15:0] idx;
    drive_t      drive;
  } drive_beat_t;

  typedef enum logic {
    ST_IDLE,
    ST_STREAM
  } stream_state_e;

endpackage

// File: src/drive_timer.sv
`timescale 1ns/1ns
module drive_timer (
  input  logic       clk,
  input  logic       reset,
  output logic [7:0] time_cnt,
  output logic       update
);
  import drive_pkg::*;

  localparam logic [7:0] last_cnt = 8'(period_len - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      time_cnt <= '0;
      update <= 1'b0;
    end else begin
      if (time_cnt == last_cnt) begin
        time_cnt <= '0;
      end else begin
        time_cnt <= time_cnt + 8'd1;
      end
      // Raised one count early so it is high while the counter sits at the last count
      update <= (time_cnt == last_cnt - 8'd1);
    end
  end

endmodule

// File: stm/stm_table.sv
`timescale 1ns/1ns
module stm_table #(
  parameter int DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   update,
  input  drive_pkg::mem_wr_t     mem_wr,
  output drive_pkg::drive_beat_t pattern_beat
);
  import drive_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  drive_t        mem [DEPTH];
  stream_state_e state;
  logic [15:0]   rd_idx;
  logic [AW-1:0] rd_addr;
  logic          wr_en;
  logic          beat_valid;
  logic [15:0]   beat_idx;
  drive_t        beat_drive;

  assign wr_en = mem_wr.valid && (mem_wr.sel == TABLE_STM) && (mem_wr.addr < 16'(DEPTH));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[mem_wr.addr[AW-1:0]] <= drive_t'(mem_wr.data);
    end
  end

  // Entry 0 goes out on the update edge, the rest follow from rd_idx
  assign rd_addr = (state == ST_IDLE) ? '0 : rd_idx[AW-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      rd_idx <= '0;
      beat_valid <= 1'b0;
      beat_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          beat_valid <= 1'b0;
          if (update) begin
            state <= ST_STREAM;
            beat_valid <= 1'b1;
            beat_idx <= '0;
            rd_idx <= 16'd1;
          end
        end
        ST_STREAM: begin
          if (rd_idx == 16'(DEPTH)) begin
            state <= ST_IDLE;
            beat_valid <= 1'b0;
          end else begin
            beat_valid <= 1'b1;
            beat_idx <= rd_idx;
            rd_idx <= rd_idx + 16'd1;
          end
        end
        default: begin
          state <= ST_IDLE;
          beat_valid <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    beat_drive <= mem[rd_addr];
  end

  assign pattern_beat = '{valid: beat_valid, idx: beat_idx, drive: beat_drive};

  // The stream must never point past the last transducer
  a_idx_range: assert property (@(posedge clk) disable iff (reset)
    pattern_beat.valid |-> (pattern_beat.idx < 16'(DEPTH)));

endmodule

// File: modulation/mod_table.sv
`timescale 1ns/1ns
module mod_table (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     update,
  input  drive_pkg::mem_wr_t       mem_wr,
  input  drive_pkg::mod_settings_t mod_settings,
  output logic [7:0]               mod_sample
);
  import drive_pkg::*;

  logic [7:0]  mem [256];
  logic [7:0]  smp_idx;
  logic [7:0]  last_idx;
  logic [15:0] period_cnt;
  logic        wr_en;
  logic        last_period;

  // Only the first 256 addresses exist
  assign wr_en = mem_wr.valid && (mem_wr.sel == TABLE_MOD) && (mem_wr.addr[15:8] == 8'd0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[mem_wr.addr[7:0]] <= mem_wr.data[7:0];
    end
  end

  // Wraps to 255 when mod_cycle is 0, giving the full table
  assign last_idx = mod_settings.mod_cycle - 8'd1;
  assign last_period = (period_cnt + 16'd1 >= mod_settings.freq_div);

  always_ff @(posedge clk) begin
    if (reset) begin
      smp_idx <= '0;
      period_cnt <= '0;
    end else if (update) begin
      if (last_period) begin
        period_cnt <= '0;
        if (smp_idx == last_idx) begin
          smp_idx <= '0;
        end else begin
          smp_idx <= smp_idx + 8'd1;
        end
      end else begin
        period_cnt <= period_cnt + 16'd1;
      end
    end
  end

  // Loaded at the period boundary so it holds steady for the whole stream
  always_ff @(posedge clk) begin
    if (update) begin
      mod_sample <= mem[smp_idx];
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (reset)
    (mod_settings.mod_cycle == 8'd0) || (smp_idx < mod_settings.mod_cycle));

endmodule

// File: src/modulator.sv
`timescale 1ns/1ns
module modulator (
  input  logic                   clk,
  input  logic                   reset,
  input  drive_pkg::drive_beat_t pattern_beat,
  input  logic [7:0]             mod_sample,
  output drive_pkg::drive_beat_t mod_beat
);

  logic [15:0] product;
  logic        out_valid;
  logic [15:0] out_idx;
  logic [7:0]  out_width;
  logic [7:0]  out_phase;

  assign product = pattern_beat.drive.intensity * mod_sample;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pattern_beat.valid;
    end
  end

  // Scale back to 8 bits, one beat per cycle
  always_ff @(posedge clk) begin
    out_idx <= pattern_beat.idx;
    out_width <= product[15:8];
    out_phase <= pattern_beat.drive.phase;
  end

  assign mod_beat = '{
    valid: out_valid,
    idx: out_idx,
    drive: '{intensity: out_width, phase: out_phase}
  };

endmodule

// File: src/pwm.sv
`timescale 1ns/1ns
module pwm #(
  parameter int DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   update,
  input  logic [7:0]             time_cnt,
  input  drive_pkg::drive_beat_t mod_beat,
  output logic [DEPTH-1:0]       pwm_out
);
  import drive_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int TW = $clog2(period_len);

  logic [DEPTH-1:0][7:0] shd_width;
  logic [DEPTH-1:0][7:0] shd_phase;
  logic [DEPTH-1:0][7:0] act_width;
  logic [DEPTH-1:0][7:0] act_phase;
  logic [AW-1:0]         wr_addr;
  logic                  wr_en;

  assign wr_en = mod_beat.valid && (mod_beat.idx < 16'(DEPTH));
  assign wr_addr = mod_beat.idx[AW-1:0];

  // Shadow side, filled by the stream
  always_ff @(posedge clk) begin
    if (reset) begin
      shd_width <= '0;
    end else if (wr_en) begin
      shd_width[wr_addr] <= mod_beat.drive.intensity;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      shd_phase[wr_addr] <= mod_beat.drive.phase;
    end
  end

  // All transducers switch together at the boundary
  always_ff @(posedge clk) begin
    if (reset) begin
      act_width <= '0;
    end else if (update) begin
      act_width <= shd_width;
    end
  end

  always_ff @(posedge clk) begin
    if (update) begin
      act_phase <= shd_phase;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pwm_out <= '0;
    end else begin
      for (int n = 0; n < DEPTH; n++) begin
        pwm_out[n] <= (TW'(time_cnt - act_phase[n]) < act_width[n]);
      end
    end
  end

  a_active_at_update: assert property (@(posedge clk) disable iff (reset)
    !update |=> ($stable(act_width) && $stable(act_phase)));

endmodule

// File: src/transducer_drive.sv
`timescale 1ns/1ns
module transducer_drive #(
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  drive_pkg::mem_wr_t       mem_wr,
  input  drive_pkg::mod_settings_t mod_settings,
  output logic [DEPTH-1:0]         pwm_out
);
  import drive_pkg::*;

  logic [7:0]  time_cnt;
  logic        update;
  drive_beat_t pattern_beat;
  logic [7:0]  mod_sample;
  drive_beat_t mod_beat;

  drive_timer drive_timer (
    .clk(clk),
    .reset(reset),
    .time_cnt(time_cnt),
    .update(update)
  );

  stm_table #(
    .DEPTH(DEPTH)
  ) stm_table (
    .clk(clk),
    .reset(reset),
    .update(update),
    .mem_wr(mem_wr),
    .pattern_beat(pattern_beat)
  );

  mod_table mod_table (
    .clk(clk),
    .reset(reset),
    .update(update),
    .mem_wr(mem_wr),
    .mod_settings(mod_settings),
    .mod_sample(mod_sample)
  );

  modulator modulator (
    .clk(clk),
    .reset(reset),
    .pattern_beat(pattern_beat),
    .mod_sample(mod_sample),
    .mod_beat(mod_beat)
  );

  pwm #(
    .DEPTH(DEPTH)
  ) pwm (
    .clk(clk),
    .reset(reset),
    .update(update),
    .time_cnt(time_cnt),
    .mod_beat(mod_beat),
    .pwm_out(pwm_out)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns
module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: sim/tb_transducer_drive.sv
`timescale 1ns/1ns
module tb_transducer_drive;
  import drive_pkg::*;

  localparam int NUM_ROWS = 4;
  localparam int NUM_CH = 8;
  localparam int MAX_SMP = 4;
  localparam int WINDOWS = 2;

  logic              clk;
  logic              reset;
  mem_wr_t           mem_wr;
  mod_settings_t     mod_settings;
  logic [NUM_CH-1:0] pwm_out;

  // Stimulus table with one row per test case
  int tab_int [NUM_ROWS][NUM_CH];
  int tab_phase [NUM_ROWS][NUM_CH];
  int tab_smp [NUM_ROWS][MAX_SMP];
  int tab_cycle [NUM_ROWS];
  int tab_div [NUM_ROWS];

  int          high_cnt [NUM_CH];
  int          rise_at [NUM_CH];
  int          value_errors;
  int          other_errors;
  logic [31:0] lfsr_state;
  bit          table_ready;

  tb_clock #(.PERIOD_NS(10)) i_clock (.clk(clk));

  transducer_drive #(
    .DEPTH(NUM_CH)
  ) i_dut (
    .clk(clk),
    .reset(reset),
    .mem_wr(mem_wr),
    .mod_settings(mod_settings),
    .pwm_out(pwm_out)
  );

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd000_0001;
    end
    return s >> 1;
  endfunction

  function automatic int random_byte();
    logic [7:0] val;
    val = '0;
    for (int b = 0; b < 8; b++) begin
      lfsr_state = next_lfsr(lfsr_state);
      val = {val[6:0], lfsr_state[0]};
    end
    return int'(val);
  endfunction

  function automatic int scaled_width(input int intensity, input int sample);
    return (intensity * sample) >> 8;
  endfunction

  // Expected high cycles of one channel over a full modulation cycle
  function automatic int expected_count(input int r, input int n);
    int sum;
    sum = 0;
    for (int k = 0; k < tab_cycle[r]; k++) begin
      sum += scaled_width(tab_int[r][n], tab_smp[r][k]);
    end
    return sum * tab_div[r];
  endfunction

  function automatic int run_cycles();
    int total;
    total = 5 + 2 * period_len;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += NUM_CH + tab_cycle[r] + 2 + 3 * period_len;
      total += WINDOWS * (period_len * tab_cycle[r] * tab_div[r] + 1);
    end
    return total + 4 * period_len;
  endfunction

  // The cycling row stays last because the sample index is only 0 while mod_cycle is 1
  task automatic build_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int n = 0; n < NUM_CH; n++) begin
        tab_int[r][n] = random_byte();
        tab_phase[r][n] = random_byte();
      end
    end
    tab_int[1] = '{200, 0, 255, 17, 128, 64, 1, 90};
    tab_phase[1] = '{0, 32, 250, 128, 5, 77, 200, 16};
    tab_smp[0] = '{255, 0, 0, 0};
    tab_smp[1] = '{128, 0, 0, 0};
    tab_smp[2] = '{77, 0, 0, 0};
    tab_smp[3] = '{255, 128, 40, 200};
    tab_cycle = '{1, 1, 1, 4};
    tab_div = '{1, 1, 1, 2};
  endtask

  task automatic write_entry(input table_sel_e sel, input int addr, input int data);
    @(negedge clk);
    mem_wr = '{valid: 1'b1, sel: sel, addr: 16'(addr), data: 16'(data)};
  endtask

  task automatic apply_row(input int r);
    @(negedge clk);
    mod_settings = '{mod_cycle: 8'(tab_cycle[r]), freq_div: 16'(tab_div[r])};
    for (int n = 0; n < NUM_CH; n++) begin
      write_entry(TABLE_STM, n, (tab_int[r][n] << 8) | tab_phase[r][n]);
    end
    for (int k = 0; k < tab_cycle[r]; k++) begin
      write_entry(TABLE_MOD, k, tab_smp[r][k]);
    end
    @(negedge clk);
    mem_wr.valid = 1'b0;
  endtask

  task automatic check_reset();
    repeat (5) begin
      @(negedge clk);
      if (pwm_out !== '0) begin
        value_errors++;
        $display("Error at %0t: pwm_out = %h during reset, expected 00", $time, pwm_out);
      end
    end
    reset = 1'b0;
    repeat (period_len) begin
      @(negedge clk);
      if (pwm_out !== '0) begin
        value_errors++;
        $display("Error at %0t: pwm_out = %h after reset, expected 00", $time, pwm_out);
      end
    end
  endtask

  // Counts high cycles and notes the first rising edge of every channel
  task automatic measure(input int len);
    logic [NUM_CH-1:0] prev;
    logic [NUM_CH-1:0] cur;
    for (int n = 0; n < NUM_CH; n++) begin
      high_cnt[n] = 0;
      rise_at[n] = -1;
    end
    @(negedge clk);
    prev = pwm_out;
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      cur = pwm_out;
      for (int n = 0; n < NUM_CH; n++) begin
        if (cur[n]) begin
          high_cnt[n]++;
        end
        if (cur[n] && !prev[n] && rise_at[n] < 0) begin
          rise_at[n] = i;
        end
      end
      prev = cur;
    end
  endtask

  task automatic check_counts(input int r);
    int exp;
    for (int n = 0; n < NUM_CH; n++) begin
      exp = expected_count(r, n);
      if (high_cnt[n] != exp) begin
        value_errors++;
        $display("Error at %0t: pwm_out[%0d] high cycles %0d, expected %0d",
                 $time, n, high_cnt[n], exp);
      end
    end
  endtask

  task automatic check_phases(input int r);
    int width;
    int lag;
    int exp;
    for (int n = 0; n < NUM_CH; n++) begin
      width = scaled_width(tab_int[r][n], tab_smp[r][0]);
      if (width == 0) begin
        if (rise_at[n] >= 0) begin
          other_errors++;
          $display("pwm_out[%0d] rose although its width is 0", n);
        end
      end else if (rise_at[n] < 0) begin
        other_errors++;
        $display("pwm_out[%0d] never rose although its width is %0d", n, width);
      end else if (scaled_width(tab_int[r][0], tab_smp[r][0]) != 0 && rise_at[0] >= 0) begin
        lag = ((rise_at[n] - rise_at[0]) % 256 + 256) % 256;
        exp = (tab_phase[r][n] - tab_phase[r][0] + 256) % 256;
        if (lag != exp) begin
          value_errors++;
          $display("Error at %0t: pwm_out[%0d] rise lag %0d, expected %0d", $time, n, lag, exp);
        end
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    mem_wr = '{valid: 1'b0, sel: TABLE_STM, addr: 16'd0, data: 16'd0};
    mod_settings = '{mod_cycle: 8'd1, freq_div: 16'd1};
    value_errors = 0;
    other_errors = 0;
    lfsr_state = 32'h1c0f_d24b;
    build_table();
    table_ready = 1'b1;
    check_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
      // Pattern and samples need two boundaries to reach the outputs
      repeat (3 * period_len) @(negedge clk);
      for (int w = 0; w < WINDOWS; w++) begin
        measure(period_len * tab_cycle[r] * tab_div[r]);
        check_counts(r);
        if (tab_cycle[r] == 1) begin
          check_phases(r);
        end
      end
    end
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = run_cycles();
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: transducer_drive.f
common/drive_pkg.sv
src/drive_timer.sv
stm/stm_table.sv
modulation/mod_table.sv
src/modulator.sv
src/pwm.sv
src/transducer_drive.sv
sim/tb_clock.sv
sim/tb_transducer_drive.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_transducer_drive
FILELIST = transducer_drive.f
OBJ_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
